// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;

	// first fetch address out of reset
	localparam word_t reset_vector = 32'h3000_0000;

	// major opcodes of the kept integer subset
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_lui = 7'b0110111;
	localparam logic [6:0] opcode_auipc = 7'b0010111;

	// funct3 shared by register and immediate forms
	localparam logic [2:0] funct3_add_sub = 3'b000;
	localparam logic [2:0] funct3_sll = 3'b001;
	localparam logic [2:0] funct3_slt = 3'b010;
	localparam logic [2:0] funct3_sltu = 3'b011;
	localparam logic [2:0] funct3_xor = 3'b100;
	localparam logic [2:0] funct3_srl_sra = 3'b101;
	localparam logic [2:0] funct3_or = 3'b110;
	localparam logic [2:0] funct3_and = 3'b111;

endpackage

// ==== rtl/core_pipe_pkg.sv ====
package core_pipe_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	// IF/ID contents
	typedef struct packed {
		rv_isa_pkg::word_t pc;
		rv_isa_pkg::inst_t inst;
	} fetch_t;

	// ID/EX contents, operands already resolved
	typedef struct packed {
		rv_isa_pkg::word_t pc;
		rv_isa_pkg::inst_t inst;
		rv_isa_pkg::word_t operand_a;
		rv_isa_pkg::word_t operand_b;
		alu_op_e alu_op;
		rv_isa_pkg::reg_idx_t rd;
		logic rd_wen;
	} id_ex_t;

	// retired instruction record, also the EX/WB register
	typedef struct packed {
		rv_isa_pkg::word_t pc;
		rv_isa_pkg::inst_t inst;
		rv_isa_pkg::reg_idx_t rd;
		logic rd_wen;
		rv_isa_pkg::word_t rd_data;
	} commit_t;

	// one in-flight result visible to decode
	typedef struct packed {
		logic valid;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t data;
	} bypass_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
	input logic clock_i,
	input logic reset_i,
	output logic fetch_req_o,
	output rv_isa_pkg::word_t fetch_addr_o,
	input logic inst_valid_i,
	input rv_isa_pkg::inst_t inst_i,
	output logic if_valid_o,
	output core_pipe_pkg::fetch_t if_o
);

	// st_req only follows reset; later requests launch on the response edge
	typedef enum logic {
		st_req,
		st_wait
	} fetch_state_e;

	fetch_state_e state_q;
	rv_isa_pkg::word_t pc_q;
	logic req_q;
	logic capture;
	logic if_valid_q;
	core_pipe_pkg::fetch_t if_q;

	assign capture = (state_q == st_wait) && inst_valid_i;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= st_req;
			req_q <= 1'b0;
			pc_q <= rv_isa_pkg::reset_vector;
		end else begin
			case (state_q)
				st_req: begin
					req_q <= 1'b1;
					state_q <= st_wait;
				end
				st_wait: begin
					// one pulse per response, addressed to the next word
					req_q <= inst_valid_i;
					if (inst_valid_i) begin
						pc_q <= pc_q + 32'd4;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			if_valid_q <= 1'b0;
		end else begin
			if_valid_q <= capture;
		end
	end

	always_ff @(posedge clock_i) begin
		if (capture) begin
			if_q <= '{pc: pc_q, inst: inst_i};
		end
	end

	assign fetch_req_o = req_q;
	assign fetch_addr_o = pc_q;
	assign if_valid_o = if_valid_q;
	assign if_o = if_q;

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input logic clock_i,
	input rv_isa_pkg::reg_idx_t rs1_i,
	input rv_isa_pkg::reg_idx_t rs2_i,
	output rv_isa_pkg::word_t rs1_data_o,
	output rv_isa_pkg::word_t rs2_data_o,
	input logic wen_i,
	input rv_isa_pkg::reg_idx_t rd_i,
	input rv_isa_pkg::word_t rd_data_i
);

	// x0 has no storage
	rv_isa_pkg::word_t regs_q [1:31];

	always_ff @(posedge clock_i) begin
		if (wen_i && (rd_i != '0)) begin
			regs_q[rd_i] <= rd_data_i;
		end
	end

	assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input logic clock_i,
	input logic reset_i,
	input logic if_valid_i,
	input core_pipe_pkg::fetch_t if_i,
	input core_pipe_pkg::bypass_t ex_bypass_i,
	input core_pipe_pkg::bypass_t wb_bypass_i,
	output logic id_valid_o,
	output core_pipe_pkg::id_ex_t id_o
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	rv_isa_pkg::reg_idx_t rs1;
	rv_isa_pkg::reg_idx_t rs2;
	rv_isa_pkg::reg_idx_t rd;
	rv_isa_pkg::word_t imm_i;
	rv_isa_pkg::word_t imm_u;
	rv_isa_pkg::word_t rs1_data;
	rv_isa_pkg::word_t rs2_data;
	rv_isa_pkg::word_t rs1_val;
	rv_isa_pkg::word_t rs2_val;
	rv_isa_pkg::word_t operand_a;
	rv_isa_pkg::word_t operand_b;
	core_pipe_pkg::alu_op_e alu_op;
	logic known;
	logic id_valid_q;
	core_pipe_pkg::id_ex_t id_q;

	// inst[30] picks sub and sra; sub only exists in the register form
	function automatic core_pipe_pkg::alu_op_e alu_from_funct(
		input logic [2:0] f3,
		input logic alt,
		input logic is_reg
	);
		core_pipe_pkg::alu_op_e op;
		op = core_pipe_pkg::alu_add;
		case (f3)
			rv_isa_pkg::funct3_add_sub:
				op = (alt && is_reg) ? core_pipe_pkg::alu_sub : core_pipe_pkg::alu_add;
			rv_isa_pkg::funct3_sll: op = core_pipe_pkg::alu_sll;
			rv_isa_pkg::funct3_slt: op = core_pipe_pkg::alu_slt;
			rv_isa_pkg::funct3_sltu: op = core_pipe_pkg::alu_sltu;
			rv_isa_pkg::funct3_xor: op = core_pipe_pkg::alu_xor;
			rv_isa_pkg::funct3_srl_sra:
				op = alt ? core_pipe_pkg::alu_sra : core_pipe_pkg::alu_srl;
			rv_isa_pkg::funct3_or: op = core_pipe_pkg::alu_or;
			rv_isa_pkg::funct3_and: op = core_pipe_pkg::alu_and;
		endcase
		return op;
	endfunction

	// youngest producer wins
	function automatic rv_isa_pkg::word_t forward(
		input rv_isa_pkg::reg_idx_t rs,
		input rv_isa_pkg::word_t rf_data,
		input core_pipe_pkg::bypass_t ex,
		input core_pipe_pkg::bypass_t wb
	);
		if (rs == '0) begin
			return '0;
		end else if (ex.valid && (ex.rd == rs)) begin
			return ex.data;
		end else if (wb.valid && (wb.rd == rs)) begin
			return wb.data;
		end
		return rf_data;
	endfunction

	assign opcode = if_i.inst[6:0];
	assign rd = if_i.inst[11:7];
	assign funct3 = if_i.inst[14:12];
	assign rs1 = if_i.inst[19:15];
	assign rs2 = if_i.inst[24:20];
	assign imm_i = {{20{if_i.inst[31]}}, if_i.inst[31:20]};
	assign imm_u = {if_i.inst[31:12], 12'b0};

	// write port fed from EX/WB, same contents as the wb bypass
	register_file u_register_file (
		.clock_i    (clock_i),
		.rs1_i      (rs1),
		.rs2_i      (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wen_i      (wb_bypass_i.valid),
		.rd_i       (wb_bypass_i.rd),
		.rd_data_i  (wb_bypass_i.data)
	);

	assign rs1_val = forward(rs1, rs1_data, ex_bypass_i, wb_bypass_i);
	assign rs2_val = forward(rs2, rs2_data, ex_bypass_i, wb_bypass_i);

	always_comb begin
		operand_a = rs1_val;
		operand_b = imm_i;
		alu_op = core_pipe_pkg::alu_pass_b;
		known = 1'b1;
		case (opcode)
			rv_isa_pkg::opcode_op: begin
				operand_b = rs2_val;
				alu_op = alu_from_funct(funct3, if_i.inst[30], 1'b1);
			end
			rv_isa_pkg::opcode_op_imm: begin
				alu_op = alu_from_funct(funct3, if_i.inst[30], 1'b0);
			end
			rv_isa_pkg::opcode_lui: begin
				operand_b = imm_u;
			end
			rv_isa_pkg::opcode_auipc: begin
				operand_a = if_i.pc;
				operand_b = imm_u;
				alu_op = core_pipe_pkg::alu_add;
			end
			// anything else retires as a no-op
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			id_valid_q <= 1'b0;
		end else begin
			id_valid_q <= if_valid_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (if_valid_i) begin
			id_q <= '{
				pc: if_i.pc,
				inst: if_i.inst,
				operand_a: operand_a,
				operand_b: operand_b,
				alu_op: alu_op,
				rd: rd,
				rd_wen: known && (rd != '0)
			};
		end
	end

	assign id_valid_o = id_valid_q;
	assign id_o = id_q;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input logic clock_i,
	input logic reset_i,
	input logic id_valid_i,
	input core_pipe_pkg::id_ex_t id_i,
	output core_pipe_pkg::bypass_t ex_bypass_o,
	output core_pipe_pkg::bypass_t wb_bypass_o,
	output logic rf_wen_o,
	output rv_isa_pkg::reg_idx_t rf_rd_o,
	output rv_isa_pkg::word_t rf_data_o,
	output logic commit_valid_o,
	output core_pipe_pkg::commit_t commit_o
);

	rv_isa_pkg::word_t a;
	rv_isa_pkg::word_t b;
	rv_isa_pkg::word_t alu_result;
	logic [4:0] shamt;
	logic wb_valid_q;
	core_pipe_pkg::commit_t wb_q;

	assign a = id_i.operand_a;
	assign b = id_i.operand_b;
	assign shamt = b[4:0];

	always_comb begin
		case (id_i.alu_op)
			core_pipe_pkg::alu_add: alu_result = a + b;
			core_pipe_pkg::alu_sub: alu_result = a - b;
			core_pipe_pkg::alu_sll: alu_result = a << shamt;
			core_pipe_pkg::alu_slt:
				alu_result = {{(rv_isa_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
			core_pipe_pkg::alu_sltu:
				alu_result = {{(rv_isa_pkg::xlen-1){1'b0}}, a < b};
			core_pipe_pkg::alu_xor: alu_result = a ^ b;
			core_pipe_pkg::alu_srl: alu_result = a >> shamt;
			core_pipe_pkg::alu_sra: alu_result = rv_isa_pkg::word_t'($signed(a) >>> shamt);
			core_pipe_pkg::alu_or: alu_result = a | b;
			core_pipe_pkg::alu_and: alu_result = a & b;
			default: alu_result = b;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= id_valid_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (id_valid_i) begin
			wb_q <= '{
				pc: id_i.pc,
				inst: id_i.inst,
				rd: id_i.rd,
				rd_wen: id_i.rd_wen,
				rd_data: alu_result
			};
		end
	end

	// result still in flight, ahead of EX/WB
	assign ex_bypass_o = '{valid: id_valid_i && id_i.rd_wen, rd: id_i.rd, data: alu_result};
	assign wb_bypass_o = '{valid: rf_wen_o, rd: wb_q.rd, data: wb_q.rd_data};

	assign rf_wen_o = wb_valid_q && wb_q.rd_wen;
	assign rf_rd_o = wb_q.rd;
	assign rf_data_o = wb_q.rd_data;

	assign commit_valid_o = wb_valid_q;
	assign commit_o = wb_q;

endmodule

// ==== rtl/rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
	input logic clock_i,
	input logic reset_i,
	output logic fetch_req_o,
	output rv_isa_pkg::word_t fetch_addr_o,
	input logic inst_valid_i,
	input rv_isa_pkg::inst_t inst_i,
	output logic commit_valid_o,
	output core_pipe_pkg::commit_t commit_o
);

	logic if_valid;
	core_pipe_pkg::fetch_t if_data;
	logic id_valid;
	core_pipe_pkg::id_ex_t id_data;
	core_pipe_pkg::bypass_t ex_bypass;
	core_pipe_pkg::bypass_t wb_bypass;

	fetch_unit u_fetch_unit (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.fetch_req_o  (fetch_req_o),
		.fetch_addr_o (fetch_addr_o),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.if_valid_o   (if_valid),
		.if_o         (if_data)
	);

	decode_stage u_decode_stage (
		.clock_i     (clock_i),
		.reset_i     (reset_i),
		.if_valid_i  (if_valid),
		.if_i        (if_data),
		.ex_bypass_i (ex_bypass),
		.wb_bypass_i (wb_bypass),
		.id_valid_o  (id_valid),
		.id_o        (id_data)
	);

	// register file write reaches decode on wb_bypass
	execute_stage u_execute_stage (
		.clock_i        (clock_i),
		.reset_i        (reset_i),
		.id_valid_i     (id_valid),
		.id_i           (id_data),
		.ex_bypass_o    (ex_bypass),
		.wb_bypass_o    (wb_bypass),
		.rf_wen_o       (),
		.rf_rd_o        (),
		.rf_data_o      (),
		.commit_valid_o (commit_valid_o),
		.commit_o       (commit_o)
	);

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 8,
	parameter int reset_cycles = 16
) (
	output logic clock_o,
	output logic reset_o
);

	initial begin
		clock_o = 1'b0;
		forever begin
			#(period_ns / 2) clock_o = ~clock_o;
		end
	end

	// released 1 ns after an edge, like every other input
	initial begin
		reset_o = 1'b1;
		repeat (reset_cycles) @(posedge clock_o);
		#1 reset_o = 1'b0;
	end

endmodule

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

	localparam int num_insts = 2000;
	localparam int clock_period_ns = 8;
	localparam int reset_cycles = 16;
	localparam int seed = 32'h3ed6_601f;
	localparam longint watchdog_ns = longint'(reset_cycles + num_insts * 8) * clock_period_ns;

	typedef struct packed {
		core_pipe_pkg::commit_t rec;
		logic known;
		logic [31:0] due_cycle;
	} expect_t;

	logic clock;
	logic reset;
	logic fetch_req;
	rv_isa_pkg::word_t fetch_addr;
	logic inst_valid;
	rv_isa_pkg::inst_t inst;
	logic commit_valid;
	core_pipe_pkg::commit_t commit;

	// architectural state of the reference model
	rv_isa_pkg::word_t model_regs [0:31];
	expect_t expect_q [$];
	int unsigned commit_count;
	int unsigned response_count;

	tb_clock_gen #(
		.period_ns    (clock_period_ns),
		.reset_cycles (reset_cycles)
	) u_clock_gen (
		.clock_o (clock),
		.reset_o (reset)
	);

	rv_core DUT (
		.clock_i        (clock),
		.reset_i        (reset),
		.fetch_req_o    (fetch_req),
		.fetch_addr_o   (fetch_addr),
		.inst_valid_i   (inst_valid),
		.inst_i         (inst),
		.commit_valid_o (commit_valid),
		.commit_o       (commit)
	);

	task automatic stop_on_error(input string msg);
		$display("error: %0t ns: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic is_kept(input rv_isa_pkg::inst_t word);
		return word[6:0] inside {rv_isa_pkg::opcode_op, rv_isa_pkg::opcode_op_imm,
			rv_isa_pkg::opcode_lui, rv_isa_pkg::opcode_auipc};
	endfunction

	// dense use of x0..x4 so most instructions depend on the previous ones
	function automatic rv_isa_pkg::inst_t random_inst(input int unsigned index);
		logic [6:0] opcode;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::reg_idx_t rs1;
		rv_isa_pkg::reg_idx_t rs2;
		int unsigned pick;
		rd = 5'($urandom_range(0, 4));
		rs1 = 5'($urandom_range(0, 4));
		rs2 = 5'($urandom_range(0, 4));
		f3 = 3'($urandom_range(0, 7));
		imm = 12'($urandom);
		f7 = 7'b0;
		pick = $urandom_range(0, 99);
		// x1..x4 come out of reset undefined, so load them first
		if (index < 4) begin
			return {imm, 5'd0, rv_isa_pkg::funct3_add_sub, 5'(index + 1), rv_isa_pkg::opcode_op_imm};
		end
		if (pick < 40) begin
			if (f3 == rv_isa_pkg::funct3_add_sub || f3 == rv_isa_pkg::funct3_srl_sra) begin
				f7 = {1'b0, 1'($urandom_range(0, 1)), 5'b0};
			end
			return {f7, rs2, rs1, f3, rd, rv_isa_pkg::opcode_op};
		end else if (pick < 75) begin
			if (f3 == rv_isa_pkg::funct3_sll) begin
				imm = {7'b0, imm[4:0]};
			end else if (f3 == rv_isa_pkg::funct3_srl_sra) begin
				imm = {1'b0, 1'($urandom_range(0, 1)), 5'b0, imm[4:0]};
			end
			return {imm, rs1, f3, rd, rv_isa_pkg::opcode_op_imm};
		end else if (pick < 83) begin
			return {20'($urandom), rd, rv_isa_pkg::opcode_lui};
		end else if (pick < 91) begin
			return {20'($urandom), rd, rv_isa_pkg::opcode_auipc};
		end
		// some other major opcode, fields random
		do begin
			opcode = {5'($urandom), 2'b11};
		end while (is_kept({25'b0, opcode}));
		return {25'($urandom), opcode};
	endfunction

	function automatic rv_isa_pkg::word_t model_result(
		input rv_isa_pkg::inst_t word,
		input rv_isa_pkg::word_t pc
	);
		rv_isa_pkg::word_t a;
		rv_isa_pkg::word_t b;
		rv_isa_pkg::word_t imm_u;
		logic [4:0] sh;
		logic alt;
		a = model_regs[word[19:15]];
		imm_u = {word[31:12], 12'b0};
		alt = word[30];
		case (word[6:0])
			rv_isa_pkg::opcode_lui: return imm_u;
			rv_isa_pkg::opcode_auipc: return pc + imm_u;
			rv_isa_pkg::opcode_op: b = model_regs[word[24:20]];
			rv_isa_pkg::opcode_op_imm: begin
				b = {{20{word[31]}}, word[31:20]};
				// addi has no subtract form
				if (word[14:12] == rv_isa_pkg::funct3_add_sub) begin
					alt = 1'b0;
				end
			end
			default: return '0;
		endcase
		sh = b[4:0];
		case (word[14:12])
			rv_isa_pkg::funct3_add_sub: return alt ? a - b : a + b;
			rv_isa_pkg::funct3_sll: return a << sh;
			rv_isa_pkg::funct3_slt: return {31'b0, $signed(a) < $signed(b)};
			rv_isa_pkg::funct3_sltu: return {31'b0, a < b};
			rv_isa_pkg::funct3_xor: return a ^ b;
			rv_isa_pkg::funct3_srl_sra: begin
				if (alt) begin
					return rv_isa_pkg::word_t'($signed(a) >>> sh);
				end
				return a >> sh;
			end
			rv_isa_pkg::funct3_or: return a | b;
			default: return a & b;
		endcase
	endfunction

	// retire in fetch order, commit due two edges after the sampling edge
	task automatic respond(input rv_isa_pkg::word_t pc, input int unsigned cycle);
		rv_isa_pkg::inst_t word;
		expect_t entry;
		word = random_inst(response_count);
		entry.known = is_kept(word);
		entry.rec.pc = pc;
		entry.rec.inst = word;
		entry.rec.rd = word[11:7];
		entry.rec.rd_wen = entry.known && (word[11:7] != 5'd0);
		entry.rec.rd_data = entry.known ? model_result(word, pc) : '0;
		entry.due_cycle = cycle + 3;
		if (entry.rec.rd_wen) begin
			model_regs[word[11:7]] = entry.rec.rd_data;
		end
		expect_q.push_back(entry);
		inst = word;
		inst_valid = 1'b1;
		response_count++;
	endtask

	task automatic check_commit(input expect_t exp);
		assert (commit.pc == exp.rec.pc && commit.inst == exp.rec.inst) else
			stop_on_error($sformatf("commit pc %h inst %h, expected pc %h inst %h",
				commit.pc, commit.inst, exp.rec.pc, exp.rec.inst));
		assert (commit.rd == exp.rec.rd && commit.rd_wen == exp.rec.rd_wen) else
			stop_on_error($sformatf("inst %h commit rd %0d wen %b, expected rd %0d wen %b",
				exp.rec.inst, commit.rd, commit.rd_wen, exp.rec.rd, exp.rec.rd_wen));
		if (exp.known) begin
			assert (commit.rd_data == exp.rec.rd_data) else
				stop_on_error($sformatf("inst %h at pc %h gave %h, expected %h",
					exp.rec.inst, exp.rec.pc, commit.rd_data, exp.rec.rd_data));
		end
	endtask

	initial begin : stimulus
		logic was_reset;
		logic pending;
		logic responded;
		logic first_cycle;
		logic expect_commit;
		int unsigned wait_cycles;
		int unsigned cycle;
		rv_isa_pkg::word_t next_addr;
		rv_isa_pkg::word_t req_addr;
		void'($urandom(seed));
		inst_valid = 1'b0;
		inst = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		pending = 1'b0;
		responded = 1'b0;
		first_cycle = 1'b1;
		cycle = 0;
		wait_cycles = 0;
		next_addr = rv_isa_pkg::reset_vector;
		req_addr = '0;
		forever begin
			@(posedge clock);
			was_reset = reset;
			cycle++;
			#1;
			inst_valid = 1'b0;
			if (was_reset) begin
				assert (!fetch_req && !commit_valid) else
					stop_on_error("fetch request or commit while in reset");
			end else begin
				expect_commit = (expect_q.size() > 0) && (expect_q[0].due_cycle == cycle);
				assert (commit_valid == expect_commit) else
					stop_on_error($sformatf("commit_valid %b, expected %b",
						commit_valid, expect_commit));
				if (expect_commit) begin
					check_commit(expect_q.pop_front());
					commit_count++;
				end
				assert (!(fetch_req && pending)) else
					stop_on_error("second fetch request before the response");
				assert (fetch_req == (first_cycle || responded)) else
					stop_on_error($sformatf("fetch_req %b, expected %b",
						fetch_req, first_cycle || responded));
				first_cycle = 1'b0;
				responded = 1'b0;
				if (fetch_req) begin
					assert (fetch_addr == next_addr) else
						stop_on_error($sformatf("fetch address %h, expected %h",
							fetch_addr, next_addr));
					req_addr = next_addr;
					next_addr = next_addr + 32'd4;
					pending = 1'b1;
					wait_cycles = $urandom_range(1, 4);
				end else if (pending && response_count < num_insts) begin
					wait_cycles--;
					if (wait_cycles == 0) begin
						respond(req_addr, cycle);
						pending = 1'b0;
						responded = 1'b1;
					end
				end
			end
		end
	end

	initial begin : run_control
		wait (commit_count == num_insts);
		// room for a stray commit to show up
		repeat (8) @(posedge clock);
		$display("All tests passed");
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: commits stopped arriving, %0d of %0d retired", commit_count, num_insts);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sources.f ====
rtl/rv_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/fetch_unit.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_core.sv
verification/tb_clock_gen.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - rtl/rv_isa_pkg.sv
      - rtl/core_pipe_pkg.sv
      - rtl/fetch_unit.sv
      - rtl/register_file.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/rv_core.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/rv_core_tb.sv
